//--- tx_chain.f
source/tx_pkg.sv
source/symbol_mapper.sv
source/srrc_shaper.sv
source/halfband_interp.sv
source/tx_output_stage.sv
source/tx_chain.sv
bench/tb_clock_gen.sv
bench/tb_tx_chain.sv

//--- Bender.yml
package:
  name: tx_chain

sources:
  - source/tx_pkg.sv
  - source/symbol_mapper.sv
  - source/srrc_shaper.sv
  - source/halfband_interp.sv
  - source/tx_output_stage.sv
  - source/tx_chain.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_tx_chain.sv

//--- bench/tb_tx_chain.sv
`timescale 1ns/1ps

module tb_tx_chain;

    localparam int NUM_HB_STAGES = 2;
    localparam int SYMBOL_REF = 4096;
    localparam int SAMPLES_PER_SYMBOL = 4 << NUM_HB_STAGES;
    localparam int STEADY_SYMBOLS = 16;
    localparam int RANDOM_SYMBOLS = 40;
    localparam int SETTLE_CYCLES = 50;
    localparam int TOTAL_SYMBOLS = 4 * STEADY_SYMBOLS + 2 * RANDOM_SYMBOLS;
    // four cycles per output sample, plus three resets and six drains
    localparam int WATCHDOG_CYCLES = TOTAL_SYMBOLS * SAMPLES_PER_SYMBOL * 4
        + 3 * 10 + 6 * SETTLE_CYCLES;

    logic sys_clk;
    logic rst;
    logic reset_req;
    tx_pkg::symbol_s sym_in;
    logic sym_in_valid;
    logic sym_in_ready;
    tx_pkg::out_sample_s tx_out;
    logic tx_out_valid;
    logic tx_out_ready;

    logic [31:0] lfsr_state = 32'hdb49969c;
    int checks = 0;
    int errors = 0;
    int accepted = 0;
    int stall_hits = 0;
    int level_fifo[$];
    int out_log[$];
    int first_run[$];
    logic [1:0] tx_symbols[$];
    logic prev_valid;
    logic prev_ready;
    int prev_data;

    tb_clock_gen clock_gen (
        .reset_req(reset_req),
        .sys_clk  (sys_clk),
        .rst      (rst)
    );

    tx_chain #(
        .NUM_HB_STAGES(NUM_HB_STAGES),
        .SYMBOL_REF   (SYMBOL_REF)
    ) dut (.*);

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // gray mapping 00, 01, 11, 10 onto -3, -1, +1, +3
    function automatic int symbol_multiplier(input logic [1:0] bits);
        case (bits)
            2'b00: return -3;
            2'b01: return -1;
            2'b11: return 1;
            default: return 3;
        endcase
    endfunction

    task automatic check_value(input string name, input int expected, input int actual,
                               input int tol);
        checks++;
        assert (actual >= expected - tol && actual <= expected + tol) else begin
            errors++;
            $display("ERROR at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("at %0t: %s", $time, what);
        end
    endtask

    always @(posedge sys_clk) begin
        if (rst) begin
            accepted = 0;
            level_fifo.delete();
            out_log.delete();
            prev_valid = 1'b0;
            prev_ready = 1'b1;
        end else begin
            if (tx_out_valid) begin
                check_true(accepted > 0, "output sample appeared before any symbol was accepted");
            end
            if (sym_in_valid && sym_in_ready) begin
                accepted++;
                level_fifo.push_back(symbol_multiplier(sym_in.bits) * SYMBOL_REF);
            end
            if (prev_valid && !prev_ready) begin
                stall_hits++;
                check_value("tx_out_valid", 1, int'(tx_out_valid), 0);
                check_value("tx_out.data", prev_data, int'($signed(tx_out.data)), 0);
            end
            if (tx_out_valid && tx_out_ready) begin
                out_log.push_back(int'($signed(tx_out.data)));
            end
            prev_valid = tx_out_valid;
            prev_ready = tx_out_ready;
            prev_data = int'($signed(tx_out.data));
        end
    end

    task automatic wait_reset_release();
        do begin
            @(negedge sys_clk);
        end while (rst);
        check_value("tx_out_valid", 0, int'(tx_out_valid), 0);
        check_value("sym_in_ready", 1, int'(sym_in_ready), 0);
    endtask

    task automatic apply_reset();
        @(posedge sys_clk);
        reset_req <= 1'b1;
        sym_in_valid <= 1'b0;
        tx_out_ready <= 1'b1;
        @(posedge sys_clk);
        reset_req <= 1'b0;
        wait_reset_release();
    endtask

    task automatic send_symbols(input bit random_flow);
        int idx;
        bit xfer;
        logic [31:0] r;
        idx = 0;
        while (idx < tx_symbols.size()) begin
            @(posedge sys_clk);
            xfer = sym_in_valid && sym_in_ready;
            if (xfer) begin
                idx++;
            end
            r = '1;
            if (random_flow) begin
                draw_bits(3, r);
            end
            tx_out_ready <= |r[1:0];
            if (!sym_in_valid || xfer) begin
                sym_in_valid <= (idx < tx_symbols.size()) && r[2];
                if (idx < tx_symbols.size()) begin
                    sym_in.bits <= tx_symbols[idx];
                end
            end
        end
    endtask

    task automatic drain_and_count();
        int expected;
        @(posedge sys_clk);
        tx_out_ready <= 1'b1;
        do begin
            @(negedge sys_clk);
            expected = accepted * SAMPLES_PER_SYMBOL;
        end while (out_log.size() < expected);
        repeat (SETTLE_CYCLES) @(negedge sys_clk);
        check_value("output transfers", accepted * SAMPLES_PER_SYMBOL, out_log.size(), 0);
    endtask

    task automatic check_steady(input logic [1:0] bits);
        int expected;
        tx_symbols.delete();
        repeat (STEADY_SYMBOLS) begin
            tx_symbols.push_back(bits);
        end
        send_symbols(1'b0);
        drain_and_count();
        // dropping two low bits divides the level by four
        expected = level_fifo[level_fifo.size() - 1] / 4;
        for (int i = out_log.size() - SAMPLES_PER_SYMBOL; i < out_log.size(); i++) begin
            check_value("tx_out.data", expected, out_log[i], 2);
        end
    endtask

    initial begin
        logic [31:0] r;
        sym_in = '0;
        sym_in_valid = 1'b0;
        tx_out_ready = 1'b1;
        reset_req = 1'b0;
        wait_reset_release();
        for (int v = 0; v < 4; v++) begin
            check_steady(v[1:0]);
        end
        apply_reset();
        tx_symbols.delete();
        for (int i = 0; i < RANDOM_SYMBOLS; i++) begin
            draw_bits(2, r);
            tx_symbols.push_back(r[1:0]);
        end
        send_symbols(1'b1);
        drain_and_count();
        first_run = out_log;
        apply_reset();
        // flipping the top bit negates every level
        for (int i = 0; i < RANDOM_SYMBOLS; i++) begin
            tx_symbols[i] = tx_symbols[i] ^ 2'b10;
        end
        send_symbols(1'b1);
        drain_and_count();
        check_value("output transfers", first_run.size(), out_log.size(), 0);
        for (int i = 0; i < first_run.size() && i < out_log.size(); i++) begin
            check_value("tx_out.data", -first_run[i], out_log[i], 0);
        end
        check_true(stall_hits > 0, "the random ready pattern never stalled a valid output");
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        $display("timeout: the run did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("checks: %0d  errors: %0d", checks, errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40,
    parameter int RESET_CYCLES = 10
) (
    input  logic reset_req,
    output logic sys_clk,
    output logic rst
);

    int remaining = RESET_CYCLES;

    initial begin
        sys_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) sys_clk = ~sys_clk;
        end
    end

    // a request restarts the full reset count
    always @(posedge sys_clk) begin
        if (reset_req) begin
            remaining <= RESET_CYCLES;
        end else if (remaining > 0) begin
            remaining <= remaining - 1;
        end
    end

    assign rst = remaining != 0;

endmodule

//--- source/tx_chain.sv
`timescale 1ns/1ps

module tx_chain #(
    parameter int NUM_HB_STAGES = 2,
    parameter int SYMBOL_REF = 4096
) (
    input  logic                sys_clk,
    input  logic                rst,
    input  tx_pkg::symbol_s     sym_in,
    input  logic                sym_in_valid,
    output logic                sym_in_ready,
    output tx_pkg::out_sample_s tx_out,
    output logic                tx_out_valid,
    input  logic                tx_out_ready
);

    tx_pkg::sample_s lvl;
    logic lvl_valid;
    logic lvl_ready;

    // hb_link[0] is the shaper output, hb_link[NUM_HB_STAGES] feeds the output stage
    tx_pkg::sample_s hb_link [NUM_HB_STAGES + 1];
    logic hb_link_valid [NUM_HB_STAGES + 1];
    logic hb_link_ready [NUM_HB_STAGES + 1];

    symbol_mapper #(
        .SYMBOL_REF(SYMBOL_REF)
    ) u_mapper (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .sym_in      (sym_in),
        .sym_in_valid(sym_in_valid),
        .sym_in_ready(sym_in_ready),
        .lvl         (lvl),
        .lvl_valid   (lvl_valid),
        .lvl_ready   (lvl_ready)
    );

    srrc_shaper u_shaper (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .lvl      (lvl),
        .lvl_valid(lvl_valid),
        .lvl_ready(lvl_ready),
        .shp      (hb_link[0]),
        .shp_valid(hb_link_valid[0]),
        .shp_ready(hb_link_ready[0])
    );

    for (genvar s = 0; s < NUM_HB_STAGES; s++) begin : g_hb
        halfband_interp u_hb (
            .sys_clk     (sys_clk),
            .rst         (rst),
            .hb_in       (hb_link[s]),
            .hb_in_valid (hb_link_valid[s]),
            .hb_in_ready (hb_link_ready[s]),
            .hb_out      (hb_link[s+1]),
            .hb_out_valid(hb_link_valid[s+1]),
            .hb_out_ready(hb_link_ready[s+1])
        );
    end

    tx_output_stage u_out (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .fin         (hb_link[NUM_HB_STAGES]),
        .fin_valid   (hb_link_valid[NUM_HB_STAGES]),
        .fin_ready   (hb_link_ready[NUM_HB_STAGES]),
        .tx_out      (tx_out),
        .tx_out_valid(tx_out_valid),
        .tx_out_ready(tx_out_ready)
    );

endmodule

//--- source/tx_output_stage.sv
`timescale 1ns/1ps

module tx_output_stage (
    input  logic                sys_clk,
    input  logic                rst,
    input  tx_pkg::sample_s     fin,
    input  logic                fin_valid,
    output logic                fin_ready,
    output tx_pkg::out_sample_s tx_out,
    output logic                tx_out_valid,
    input  logic                tx_out_ready
);

    localparam int DROP = tx_pkg::SAMPLE_W - tx_pkg::OUT_W;
    localparam int OUT_MAX = 2 ** (tx_pkg::OUT_W - 1) - 1;

    tx_pkg::acc_t rounded;
    logic signed [tx_pkg::OUT_W-1:0] clipped;
    logic accept;

    // symmetric limits keep the chain odd
    always_comb begin
        rounded = tx_pkg::round_shift(tx_pkg::acc_t'(fin.data), DROP);
        if (rounded > tx_pkg::acc_t'(OUT_MAX)) begin
            clipped = {1'b0, {(tx_pkg::OUT_W - 1){1'b1}}};
        end else if (rounded < -tx_pkg::acc_t'(OUT_MAX)) begin
            clipped = {1'b1, {(tx_pkg::OUT_W - 2){1'b0}}, 1'b1};
        end else begin
            clipped = rounded[tx_pkg::OUT_W-1:0];
        end
    end

    assign fin_ready = !tx_out_valid || tx_out_ready;
    assign accept = fin_valid && fin_ready;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            tx_out_valid <= 1'b0;
        end else if (accept) begin
            tx_out_valid <= 1'b1;
        end else if (tx_out_ready) begin
            tx_out_valid <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept) begin
            tx_out.data <= clipped;
        end
    end

endmodule

//--- source/halfband_interp.sv
`timescale 1ns/1ps

module halfband_interp (
    input  logic            sys_clk,
    input  logic            rst,
    input  tx_pkg::sample_s hb_in,
    input  logic            hb_in_valid,
    output logic            hb_in_ready,
    output tx_pkg::sample_s hb_out,
    output logic            hb_out_valid,
    input  logic            hb_out_ready
);

    // only the non-zero branch needs a delay line slot per tap
    localparam int DEPTH = (tx_pkg::HB_TAPS + 1) / 2;
    localparam int CENTRE = tx_pkg::HB_TAPS / 2;

    tx_pkg::sample_t dl [DEPTH];
    logic odd_phase;
    logic accept;
    tx_pkg::acc_t centre_sum;
    tx_pkg::acc_t side_sum;

    assign hb_in_ready = !hb_out_valid || (hb_out_ready && odd_phase);
    assign accept = hb_in_valid && hb_in_ready;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            for (int k = 0; k < DEPTH; k++) begin
                dl[k] <= '0;
            end
            odd_phase <= 1'b0;
            hb_out_valid <= 1'b0;
        end else if (accept) begin
            dl[0] <= hb_in.data;
            for (int k = 1; k < DEPTH; k++) begin
                dl[k] <= dl[k-1];
            end
            odd_phase <= 1'b0;
            hb_out_valid <= 1'b1;
        end else if (hb_out_valid && hb_out_ready) begin
            if (odd_phase) begin
                hb_out_valid <= 1'b0;
            end
            odd_phase <= !odd_phase;
        end
    end

    // centre tap lines up with dl[DEPTH/2], half a sample ahead of the side sum
    always_comb begin
        centre_sum = tx_pkg::acc_t'(dl[DEPTH/2]) * tx_pkg::acc_t'(tx_pkg::HB_COEF[CENTRE]);
        side_sum = '0;
        for (int i = 0; i < DEPTH / 2; i++) begin
            side_sum = side_sum
                + (tx_pkg::acc_t'(dl[i]) + tx_pkg::acc_t'(dl[DEPTH-1-i]))
                * tx_pkg::acc_t'(tx_pkg::HB_COEF[2 * i]);
        end
    end

    // one bit less of shift gives the gain of two
    assign hb_out.data = tx_pkg::sample_t'(tx_pkg::round_shift(
        odd_phase ? side_sum : centre_sum, tx_pkg::COEF_SHIFT - 1));

endmodule

//--- source/srrc_shaper.sv
`timescale 1ns/1ps

module srrc_shaper (
    input  logic            sys_clk,
    input  logic            rst,
    input  tx_pkg::sample_s lvl,
    input  logic            lvl_valid,
    output logic            lvl_ready,
    output tx_pkg::sample_s shp,
    output logic            shp_valid,
    input  logic            shp_ready
);

    // past levels seen by the longest branch
    localparam int DEPTH = (tx_pkg::SRRC_TAPS + 3) / 4;

    tx_pkg::sample_t dl [DEPTH];
    logic [1:0] phase;
    logic accept;
    tx_pkg::acc_t acc;

    // a new level may enter on the same edge the last phase leaves
    assign lvl_ready = !shp_valid || (shp_ready && phase == 2'd3);
    assign accept = lvl_valid && lvl_ready;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            for (int k = 0; k < DEPTH; k++) begin
                dl[k] <= '0;
            end
            phase <= 2'd0;
            shp_valid <= 1'b0;
        end else if (accept) begin
            dl[0] <= lvl.data;
            for (int k = 1; k < DEPTH; k++) begin
                dl[k] <= dl[k-1];
            end
            phase <= 2'd0;
            shp_valid <= 1'b1;
        end else if (shp_valid && shp_ready) begin
            if (phase == 2'd3) begin
                shp_valid <= 1'b0;
            end
            phase <= phase + 2'd1;
        end
    end

    // phase p uses taps p, p+4, p+8, ... against dl[0], dl[1], dl[2], ...
    always_comb begin
        acc = '0;
        for (int k = 0; k < DEPTH; k++) begin
            if (4 * k + int'(phase) < tx_pkg::SRRC_TAPS) begin
                acc = acc + tx_pkg::acc_t'(dl[k])
                    * tx_pkg::acc_t'(tx_pkg::SRRC_COEF[4 * k + int'(phase)]);
            end
        end
    end

    assign shp.data = tx_pkg::sample_t'(tx_pkg::round_shift(acc, tx_pkg::COEF_SHIFT));

endmodule

//--- source/symbol_mapper.sv
`timescale 1ns/1ps

module symbol_mapper #(
    parameter int SYMBOL_REF = 4096
) (
    input  logic            sys_clk,
    input  logic            rst,
    input  tx_pkg::symbol_s sym_in,
    input  logic            sym_in_valid,
    output logic            sym_in_ready,
    output tx_pkg::sample_s lvl,
    output logic            lvl_valid,
    input  logic            lvl_ready
);

    tx_pkg::level_e level;
    int multiplier;
    logic accept;

    // gray coded constellation
    always_comb begin
        case (sym_in.bits)
            2'b00: level = tx_pkg::LEVEL_N3;
            2'b01: level = tx_pkg::LEVEL_N1;
            2'b11: level = tx_pkg::LEVEL_P1;
            default: level = tx_pkg::LEVEL_P3;
        endcase
    end

    always_comb begin
        case (level)
            tx_pkg::LEVEL_N3: multiplier = -3;
            tx_pkg::LEVEL_N1: multiplier = -1;
            tx_pkg::LEVEL_P1: multiplier = 1;
            default: multiplier = 3;
        endcase
    end

    assign sym_in_ready = !lvl_valid || lvl_ready;
    assign accept = sym_in_valid && sym_in_ready;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            lvl_valid <= 1'b0;
        end else if (accept) begin
            lvl_valid <= 1'b1;
        end else if (lvl_ready) begin
            lvl_valid <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept) begin
            lvl.data <= tx_pkg::sample_t'(multiplier * SYMBOL_REF);
        end
    end

endmodule

//--- source/tx_pkg.sv
package tx_pkg;

    localparam int SAMPLE_W = 18;
    localparam int OUT_W = 16;
    localparam int COEF_W = 18;
    localparam int COEF_SHIFT = 17;
    // accumulator headroom for the longest polyphase branch
    localparam int ACC_W = SAMPLE_W + COEF_W + 4;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    typedef struct packed {
        logic [1:0] bits;
    } symbol_s;

    typedef struct packed {
        sample_t data;
    } sample_s;

    typedef struct packed {
        logic signed [OUT_W-1:0] data;
    } out_sample_s;

    typedef enum logic [1:0] {
        LEVEL_N3,
        LEVEL_N1,
        LEVEL_P1,
        LEVEL_P3
    } level_e;

    // each of the four branches (taps k, k+4, ...) sums to 2**COEF_SHIFT
    localparam int SRRC_TAPS = 33;
    localparam coef_t SRRC_COEF [SRRC_TAPS] = '{
        -299, -500, 1667, 2152, 500, -2152, -2337, 2028,
        2000, 2028, -11683, -20517, -2200, 20517, 77889, 127516,
        131070,
        127516, 77889, 20517, -2200, -20517, -11683, 2028, 2000,
        2028, -2337, -2152, 500, 2152, 1667, -500, -299
    };

    // stored at half scale, both branches reach 2**COEF_SHIFT once the
    // interpolation gain of two is applied
    localparam int HB_TAPS = 11;
    localparam coef_t HB_COEF [HB_TAPS] = '{
        768, 0, -6400, 0, 38400, 65536, 38400, 0, -6400, 0, 768
    };

    // round to nearest, ties away from zero, so that f(-x) == -f(x)
    function automatic acc_t round_shift(input acc_t value, input int shift);
        acc_t biased;
        biased = value + (acc_t'(1) <<< (shift - 1));
        if (value < 0) begin
            biased = biased - acc_t'(1);
        end
        return biased >>> shift;
    endfunction

endpackage
